// File: rtl/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// ******************************
// datapath widths
// ******************************
`define XLEN         32
`define BYTE_W       8
`define IMM_W        16

// register file
`define REG_COUNT    32
`define REG_IDX_W    5

// instruction memory
`define IMEM_DEPTH   256
`define IMEM_ADDR_W  8

// receive buffer, in bytes
`define RX_DEPTH     64

// ******************************
// instruction word fields
// ******************************
`define OPC_W        6
`define FUNCT_W      6
`define SHAMT_W      5

`endif

// File: rtl/isa_pkg.sv
`include "core_consts.svh"

package isa_pkg;

    // major opcodes
    typedef enum logic [`OPC_W-1:0] {
        OP_SPECIAL = 6'b000000,
        OP_BL      = 6'b000001,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_BG      = 6'b000110,
        OP_ADDI    = 6'b001000,
        OP_SLLI    = 6'b111110
    } opcode_t;

    // functions under OP_SPECIAL
    typedef enum logic [`FUNCT_W-1:0] {
        FN_RET = 6'b000000,
        FN_MOV = 6'b001001,
        FN_OUT = 6'b010101,
        FN_ADD = 6'b100000,
        FN_SUB = 6'b100010,
        FN_IN  = 6'b101010
    } funct_t;

    typedef struct packed {
        opcode_t                opcode;
        logic [`REG_IDX_W-1:0]  rs;
        logic [`REG_IDX_W-1:0]  rt;
        logic [`REG_IDX_W-1:0]  rd;
        logic [`SHAMT_W-1:0]    shamt;
        funct_t                 funct;
    } r_form_t;

    typedef struct packed {
        opcode_t                opcode;
        logic [`REG_IDX_W-1:0]  rs;
        logic [`REG_IDX_W-1:0]  rt;
        logic [`IMM_W-1:0]      imm;
    } i_form_t;

    // one word, two readings
    typedef union packed {
        r_form_t r;
        i_form_t i;
    } instr_u;

    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_PASS, ALU_SHIFT} alu_op_t;
    typedef enum logic [1:0] {BR_EQ, BR_NE, BR_LT, BR_GT} br_op_t;

endpackage

// File: rtl/io_pkg.sv
`include "core_consts.svh"

package io_pkg;

    // one byte on the host link
    typedef logic [`BYTE_W-1:0] byte_t;

    // index into the receive buffer
    typedef logic [$clog2(`RX_DEPTH)-1:0] rx_idx_t;

endpackage

// File: rtl/rx_buffer.sv
`include "core_consts.svh"

module rx_buffer #(
    parameter int DEPTH = `RX_DEPTH
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               rx_valid,
    input  io_pkg::byte_t      rx_data,
    input  logic               word_take,
    output logic               word_ready,
    output logic [`XLEN-1:0]   rx_word
);
    import io_pkg::*;

    localparam int CNT_W = $clog2(DEPTH) + 1;

    byte_t              mem [DEPTH];
    rx_idx_t            wr_idx;
    rx_idx_t            rd_idx;
    logic [CNT_W-1:0]   unread;
    logic               seen;
    logic               capture;

    // one byte per high phase of rx_valid
    assign capture = rx_valid && !seen;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            seen <= 1'b0;
        end else if (capture) begin
            seen <= 1'b1;
        end else if (!rx_valid) begin
            seen <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            mem[wr_idx] <= rx_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_idx <= '0;
            rd_idx <= '0;
            unread <= '0;
        end else begin
            if (capture) begin
                wr_idx <= wr_idx + rx_idx_t'(1);
            end
            if (word_take) begin
                rd_idx <= rd_idx + rx_idx_t'(4);
            end
            unread <= unread + CNT_W'(capture) - (word_take ? CNT_W'(4) : CNT_W'(0));
        end
    end

    // lowest byte first
    assign rx_word = {mem[rd_idx + rx_idx_t'(3)],
                      mem[rd_idx + rx_idx_t'(2)],
                      mem[rd_idx + rx_idx_t'(1)],
                      mem[rd_idx]};

    assign word_ready = (unread >= CNT_W'(4));

    take_needs_word: assert property (@(posedge clk) disable iff (!rstn)
        word_take |-> word_ready);

endmodule

// File: rtl/alu_unit.sv
`include "core_consts.svh"

module alu_unit (
    input  isa_pkg::alu_op_t   alu_op,
    input  logic [`XLEN-1:0]   operand_a,
    input  logic [`XLEN-1:0]   operand_b,
    output logic [`XLEN-1:0]   alu_result
);
    import isa_pkg::*;

    logic             shift_neg;
    logic [`XLEN-1:0] shift_mag;
    logic [`XLEN-1:0] shifted;

    // negative amount means shift right by its magnitude
    assign shift_neg = operand_b[`XLEN-1];
    assign shift_mag = shift_neg ? (~operand_b + 1'b1) : operand_b;
    assign shifted   = shift_neg ? (operand_a >> shift_mag) : (operand_a << shift_mag);

    always_comb begin
        case (alu_op)
            ALU_ADD: begin
                alu_result = operand_a + operand_b;
            end
            ALU_SUB: begin
                alu_result = operand_a - operand_b;
            end
            ALU_SHIFT: begin
                alu_result = shifted;
            end
            // mov, in and out carry operand_a through
            default: begin
                alu_result = operand_a;
            end
        endcase
    end

endmodule

// File: rtl/branch_resolver.sv
`include "core_consts.svh"

module branch_resolver (
    input  isa_pkg::br_op_t    br_op,
    input  logic [`XLEN-1:0]   operand_a,
    input  logic [`XLEN-1:0]   operand_b,
    input  logic               br_valid,
    output logic               mispredict
);
    import isa_pkg::*;

    logic signed [`XLEN-1:0] a_s;
    logic signed [`XLEN-1:0] b_s;
    logic                    taken;

    assign a_s = operand_a;
    assign b_s = operand_b;

    // signed compare
    always_comb begin
        case (br_op)
            BR_EQ: begin
                taken = (a_s == b_s);
            end
            BR_NE: begin
                taken = (a_s != b_s);
            end
            BR_LT: begin
                taken = (a_s < b_s);
            end
            default: begin
                taken = (a_s > b_s);
            end
        endcase
    end

    // fetch always assumed taken
    assign mispredict = br_valid && !taken;

endmodule

// File: rtl/core_pipeline.sv
`include "core_consts.svh"

module core_pipeline (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     prog_we,
    input  logic [`IMEM_ADDR_W-1:0]  prog_addr,
    input  logic [`XLEN-1:0]         prog_data,
    input  logic                     word_ready,
    input  logic [`XLEN-1:0]         rx_word,
    input  logic                     tx_busy,
    input  logic [`XLEN-1:0]         alu_result,
    input  logic                     mispredict,
    output logic                     word_take,
    output logic                     tx_valid,
    output io_pkg::byte_t            tx_data,
    output logic                     halted,
    output isa_pkg::alu_op_t         alu_op,
    output isa_pkg::br_op_t          br_op,
    output logic                     br_valid,
    output logic [`XLEN-1:0]         operand_a,
    output logic [`XLEN-1:0]         operand_b
);
    import isa_pkg::*;

    logic [`XLEN-1:0]        imem [`IMEM_DEPTH];
    logic [`XLEN-1:0]        regs [`REG_COUNT];
    logic [`REG_COUNT-1:0]   busy;
    logic [`IMEM_ADDR_W-1:0] pc;
    logic [`IMEM_ADDR_W-1:0] pred_pc;
    instr_u                  fw;
    logic                    fetch_br;

    // fetch/decode slot
    logic                    if_valid;
    instr_u                  if_instr;
    logic [`IMEM_ADDR_W-1:0] if_pc;

    // decode
    logic [`REG_IDX_W-1:0]   src1;
    logic [`REG_IDX_W-1:0]   src2;
    logic [`REG_IDX_W-1:0]   dst;
    logic                    use1, use2, use_dst;
    logic                    dec_in, dec_out, dec_ret, dec_br, dec_imm_b;
    alu_op_t                 dec_alu_op;
    br_op_t                  dec_br_op;
    logic                    out_pending, hazard, advance, issue;

    // decode/execute slot
    logic                    ex_valid;
    logic                    ex_is_br, ex_is_out, ex_is_ret, ex_wr;
    logic [`REG_IDX_W-1:0]   ex_rd;
    logic [`IMEM_ADDR_W-1:0] ex_pc;
    logic [`XLEN-1:0]        ex_a;
    logic [`XLEN-1:0]        ex_b;
    alu_op_t                 ex_alu_op;
    br_op_t                  ex_br_op;

    // execute/writeback slot
    logic                    wb_valid;
    logic                    wb_is_out, wb_is_ret, wb_wr;
    logic [`REG_IDX_W-1:0]   wb_rd;
    logic [`XLEN-1:0]        wb_result;

    // program load, only while reset is held
    always_ff @(posedge clk) begin
        if (prog_we && !rstn) begin
            imem[prog_addr] <= prog_data;
        end
    end

    // ******************************
    // fetch, predict taken
    // ******************************
    assign fw       = imem[pc];
    assign fetch_br = fw.i.opcode inside {OP_BEQ, OP_BNE, OP_BL, OP_BG};
    assign pred_pc  = fetch_br ? pc + fw.i.imm[`IMEM_ADDR_W-1:0] : pc + 1'b1;

    // ******************************
    // decode
    // ******************************
    assign src1 = if_instr.i.rs;
    assign src2 = if_instr.i.rt;

    always_comb begin
        dst        = if_instr.i.rt;
        use1       = 1'b0;
        use2       = 1'b0;
        use_dst    = 1'b0;
        dec_in     = 1'b0;
        dec_out    = 1'b0;
        dec_ret    = 1'b0;
        dec_br     = 1'b0;
        dec_imm_b  = 1'b0;
        dec_alu_op = ALU_PASS;
        dec_br_op  = BR_EQ;
        case (if_instr.i.opcode)
            OP_SPECIAL: begin
                case (if_instr.r.funct)
                    FN_ADD, FN_SUB: begin
                        use1       = 1'b1;
                        use2       = 1'b1;
                        use_dst    = 1'b1;
                        dst        = if_instr.r.rd;
                        dec_alu_op = (if_instr.r.funct == FN_SUB) ? ALU_SUB : ALU_ADD;
                    end
                    FN_MOV: begin
                        use1    = 1'b1;
                        use_dst = 1'b1;
                    end
                    // in writes the rs field
                    FN_IN: begin
                        use_dst = 1'b1;
                        dst     = if_instr.r.rs;
                        dec_in  = 1'b1;
                    end
                    FN_OUT: begin
                        use1    = 1'b1;
                        dec_out = 1'b1;
                    end
                    FN_RET: begin
                        dec_ret = 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
            OP_ADDI, OP_SLLI: begin
                use1       = 1'b1;
                use_dst    = 1'b1;
                dec_imm_b  = 1'b1;
                dec_alu_op = (if_instr.i.opcode == OP_SLLI) ? ALU_SHIFT : ALU_ADD;
            end
            OP_BEQ, OP_BNE, OP_BL, OP_BG: begin
                use1   = 1'b1;
                use2   = 1'b1;
                dec_br = 1'b1;
                case (if_instr.i.opcode)
                    OP_BNE: dec_br_op = BR_NE;
                    OP_BL: dec_br_op = BR_LT;
                    OP_BG: dec_br_op = BR_GT;
                    default: dec_br_op = BR_EQ;
                endcase
            end
            default: begin
            end
        endcase
    end

    // sender looks free only once no older out is in flight
    assign out_pending = (ex_valid && ex_is_out) || (wb_valid && wb_is_out);

    assign hazard = (use1 && busy[src1]) || (use2 && busy[src2]) || (use_dst && busy[dst])
                    || (dec_in && !word_ready) || (dec_out && (tx_busy || out_pending));
    assign advance   = !if_valid || !hazard;
    assign issue     = if_valid && !hazard && !mispredict && !halted;
    assign word_take = issue && dec_in;

    // ******************************
    // control state
    // ******************************
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc       <= '0;
            if_valid <= 1'b0;
            ex_valid <= 1'b0;
            wb_valid <= 1'b0;
            busy     <= '0;
            halted   <= 1'b0;
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (!halted) begin
            if (wb_valid && wb_wr) begin
                regs[wb_rd] <= wb_result;
                busy[wb_rd] <= 1'b0;
            end
            if (wb_valid && wb_is_ret) begin
                halted <= 1'b1;
            end
            wb_valid <= ex_valid;
            ex_valid <= issue;
            if (issue && use_dst) begin
                busy[dst] <= 1'b1;
            end
            if (mispredict) begin
                // drop fetch and decode, resume after the branch
                pc       <= ex_pc + 1'b1;
                if_valid <= 1'b0;
                busy     <= '0;
            end else if (advance) begin
                pc       <= pred_pc;
                if_valid <= 1'b1;
            end
        end
    end

    // payload, qualified by the valid bits above
    always_ff @(posedge clk) begin
        if (advance) begin
            if_instr <= fw;
            if_pc    <= pc;
        end
        ex_a      <= dec_in ? rx_word : regs[src1];
        ex_b      <= dec_imm_b ? {{(`XLEN-`IMM_W){if_instr.i.imm[`IMM_W-1]}}, if_instr.i.imm}
                               : regs[src2];
        ex_alu_op <= dec_alu_op;
        ex_br_op  <= dec_br_op;
        ex_is_br  <= dec_br;
        ex_is_out <= dec_out;
        ex_is_ret <= dec_ret;
        ex_wr     <= use_dst;
        ex_rd     <= dst;
        ex_pc     <= if_pc;
        wb_result <= alu_result;
        wb_is_out <= ex_is_out;
        wb_is_ret <= ex_is_ret;
        wb_wr     <= ex_wr;
        wb_rd     <= ex_rd;
    end

    assign alu_op    = ex_alu_op;
    assign br_op     = ex_br_op;
    assign br_valid  = ex_valid && ex_is_br;
    assign operand_a = ex_a;
    assign operand_b = ex_b;

    assign tx_valid = wb_valid && wb_is_out && !halted;
    assign tx_data  = wb_result[`BYTE_W-1:0];

    prog_only_in_reset: assert property (@(posedge clk) prog_we |-> !rstn);

endmodule

// File: rtl/link_core_top.sv
`include "core_consts.svh"

module link_core_top (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     rx_valid,
    input  io_pkg::byte_t            rx_data,
    input  logic                     tx_busy,
    input  logic                     prog_we,
    input  logic [`IMEM_ADDR_W-1:0]  prog_addr,
    input  logic [`XLEN-1:0]         prog_data,
    output logic                     tx_valid,
    output io_pkg::byte_t            tx_data,
    output logic                     halted
);
    import isa_pkg::*;

    logic             word_ready;
    logic             word_take;
    logic [`XLEN-1:0] rx_word;
    alu_op_t          alu_op;
    br_op_t           br_op;
    logic             br_valid;
    logic [`XLEN-1:0] operand_a;
    logic [`XLEN-1:0] operand_b;
    logic [`XLEN-1:0] alu_result;
    logic             mispredict;

    rx_buffer u_rx_buffer (
        .clk        (clk),
        .rstn       (rstn),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .word_take  (word_take),
        .word_ready (word_ready),
        .rx_word    (rx_word)
    );

    core_pipeline u_core_pipeline (
        .clk        (clk),
        .rstn       (rstn),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .word_ready (word_ready),
        .rx_word    (rx_word),
        .tx_busy    (tx_busy),
        .alu_result (alu_result),
        .mispredict (mispredict),
        .word_take  (word_take),
        .tx_valid   (tx_valid),
        .tx_data    (tx_data),
        .halted     (halted),
        .alu_op     (alu_op),
        .br_op      (br_op),
        .br_valid   (br_valid),
        .operand_a  (operand_a),
        .operand_b  (operand_b)
    );

    // execute units share the operands
    alu_unit u_alu_unit (
        .alu_op     (alu_op),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .alu_result (alu_result)
    );

    branch_resolver u_branch_resolver (
        .br_op      (br_op),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .br_valid   (br_valid),
        .mispredict (mispredict)
    );

endmodule

// File: verif/tb_link_core.sv
`include "core_consts.svh"

module tb_link_core;
    import io_pkg::*;

    localparam int TIMEOUT    = 2000;
    localparam int HALT_WATCH = 100;

    logic                    clk;
    logic                    rstn;
    logic                    rx_valid;
    byte_t                   rx_data;
    logic                    tx_busy;
    logic                    prog_we;
    logic [`IMEM_ADDR_W-1:0] prog_addr;
    logic [`XLEN-1:0]        prog_data;
    logic                    tx_valid;
    byte_t                   tx_data;
    logic                    halted;

    // trace contents
    logic [`IMEM_ADDR_W-1:0] prog_addr_q [$];
    logic [`XLEN-1:0]        prog_word_q [$];
    int                      in_gap_q [$];
    byte_t                   in_byte_q [$];
    int                      exp_test_q [$];
    byte_t                   exp_byte_q [$];
    int                      halt_test;
    logic                    halt_exp;

    int     errors;
    int     test_errs;
    int     checks;
    int     tests_passed;
    int     tests_failed;
    bit     aborted;
    integer seed;
    int     tx_count;
    int     busy_left;
    int     hold;

    link_core_top DUT (
        .clk       (clk),
        .rstn      (rstn),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .tx_busy   (tx_busy),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data),
        .halted    (halted)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ******************************
    // host sender model
    // ******************************
    // busy 20 cycles after every third byte and up to 3 random cycles after others
    always @(posedge clk) begin
        if (!rstn) begin
            tx_busy   <= 1'b0;
            busy_left <= 0;
        end else if (tx_valid) begin
            if (tx_busy) begin
                $display("tx_valid was raised while tx_busy was high");
                errors++;
                test_errs++;
            end
            tx_count++;
            hold = (tx_count % 3 == 0) ? 20 : ($random(seed) & 3);
            busy_left <= hold;
            tx_busy   <= (hold != 0);
        end else if (busy_left > 1) begin
            busy_left <= busy_left - 1;
        end else begin
            busy_left <= 0;
            tx_busy   <= 1'b0;
        end
    end

    task automatic read_trace();
        integer           fd;
        integer           rc;
        logic [7:0]       kind;
        int               a;
        logic [31:0]      b;
        logic [8*128-1:0] rest;
        bit               more;
        fd = $fopen("verif/link_core_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/link_core_trace.txt");
            aborted = 1'b1;
        end else begin
            more = 1'b1;
            while (more) begin
                rc = $fscanf(fd, " %c", kind);
                if (rc != 1) begin
                    more = 1'b0;
                end else if (kind == "#") begin
                    rc = $fgets(rest, fd);
                end else begin
                    rc = $fscanf(fd, " %d %h", a, b);
                    case (kind)
                        "P": begin
                            prog_addr_q.push_back(`IMEM_ADDR_W'(a));
                            prog_word_q.push_back(b);
                        end
                        "I": begin
                            in_gap_q.push_back(a);
                            in_byte_q.push_back(byte_t'(b));
                        end
                        "E": begin
                            exp_test_q.push_back(a);
                            exp_byte_q.push_back(byte_t'(b));
                        end
                        "H": begin
                            halt_test = a;
                            halt_exp  = b[0];
                        end
                        default: begin
                            $display("unknown line kind %c in the trace file", kind);
                            aborted = 1'b1;
                        end
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    // program goes in while reset is held
    task automatic load_program();
        for (int i = 0; i < prog_word_q.size(); i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= prog_addr_q[i];
            prog_data <= prog_word_q[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    // each byte is a two-cycle rx_valid level followed by at least one low cycle
    task automatic drive_inputs();
        for (int i = 0; i < in_byte_q.size(); i++) begin
            repeat (in_gap_q[i]) @(posedge clk);
            rx_valid <= 1'b1;
            rx_data  <= in_byte_q[i];
            repeat (2) @(posedge clk);
            rx_valid <= 1'b0;
            @(posedge clk);
        end
    endtask

    task automatic wait_for_tx(output bit seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < TIMEOUT) begin
            @(posedge clk);
            n++;
            seen = tx_valid;
        end
    endtask

    task automatic check_byte(input byte_t got, input byte_t exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED tx_data: got %h, expected %h", got, exp);
            errors++;
            test_errs++;
        end
    endtask

    task automatic check_halt(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED halted: got %h, expected %h", got, exp);
            errors++;
            test_errs++;
        end
    endtask

    task automatic report_test(input int num);
        if (test_errs == 0) begin
            $display("test %0d done, no errors", num);
            tests_passed++;
        end else begin
            $display("test %0d done, %0d errors", num, test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    // ******************************
    // main sequence
    // ******************************
    initial begin
        bit seen;
        int cur_test;
        int n;
        int extra_tx;
        rstn      = 1'b0;
        rx_valid  = 1'b0;
        rx_data   = '0;
        tx_busy   = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        errors       = 0;
        test_errs    = 0;
        checks       = 0;
        tests_passed = 0;
        tests_failed = 0;
        aborted      = 1'b0;
        seed         = 52;
        tx_count     = 0;
        busy_left    = 0;
        hold         = 0;
        halt_test    = 0;
        halt_exp     = 1'b1;

        read_trace();
        load_program();
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        fork
            drive_inputs();
        join_none

        cur_test = (exp_test_q.size() > 0) ? exp_test_q[0] : halt_test;
        for (int i = 0; i < exp_byte_q.size(); i++) begin
            if (!aborted) begin
                if (exp_test_q[i] != cur_test) begin
                    report_test(cur_test);
                    cur_test = exp_test_q[i];
                end
                wait_for_tx(seen);
                if (seen) begin
                    check_byte(tx_data, exp_byte_q[i]);
                end else begin
                    $display("no tx_valid within %0d cycles in test %0d", TIMEOUT, cur_test);
                    errors++;
                    test_errs++;
                    aborted = 1'b1;
                end
            end
        end

        if (!aborted) begin
            report_test(cur_test);
            cur_test = halt_test;
            // any byte from here on is one too many
            extra_tx = 0;
            seen     = 1'b0;
            n        = 0;
            while (!seen && n < TIMEOUT) begin
                @(posedge clk);
                n++;
                seen = halted;
                if (tx_valid) begin
                    extra_tx++;
                end
            end
            if (!seen) begin
                $display("halted did not rise within %0d cycles", TIMEOUT);
                errors++;
                test_errs++;
            end
            repeat (HALT_WATCH) begin
                @(posedge clk);
                if (tx_valid) begin
                    extra_tx++;
                end
            end
            // halted holds until the next reset
            check_halt(halted, halt_exp);
            if (extra_tx != 0) begin
                $display("%0d unexpected tx_valid pulses near the halt", extra_tx);
                errors++;
                test_errs++;
            end
            report_test(halt_test);
        end else begin
            report_test(cur_test);
        end

        $display("summary: %0d tests passed, %0d tests failed, %0d compares, %0d errors",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0 && !aborted) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/io_pkg.sv
rtl/rx_buffer.sv
rtl/alu_unit.sv
rtl/branch_resolver.sv
rtl/core_pipeline.sv
rtl/link_core_top.sv
verif/tb_link_core.sv

// File: verif/link_core_trace.txt
# P: imem address (dec), instruction word (hex)   I: idle cycles before byte (dec), byte (hex)
# E: test number (dec), expected tx byte (hex)    H: test number (dec), expected halted
# test 1, arithmetic
P 0 20010071
P 1 2002FFED
P 2 00221820
P 3 00432022
P 4 F8650002
P 5 00A60009
P 6 F8C7FFFC
P 7 00800015
P 8 00E00015
# test 2, branches
P 9 04820002
P 10 00200015
P 11 18820002
P 12 00400015
P 13 14440002
P 14 00200015
P 15 04220002
P 16 10420002
P 17 00200015
P 18 00600015
# test 3, input word split by shifts
P 19 0100002A
P 20 01000015
P 21 F909FFF8
P 22 01200015
P 23 F90AFFF0
P 24 01400015
P 25 F90BFFE8
P 26 01600015
# test 4, late input
P 27 00C00015
P 28 0180002A
P 29 01816820
P 30 01A00015
# test 5, burst of outs, then halt
P 31 00200015
P 32 00400015
P 33 00600015
P 34 01A00015
P 35 00000000
P 36 00200015
P 37 00400015
P 38 00000000
# input bytes
I 2 3C
I 1 A7
I 0 52
I 3 19
I 250 C4
I 60 0B
I 60 6E
I 60 90
# expected output
E 1 8F
E 1 17
E 2 ED
E 2 5E
E 3 3C
E 3 A7
E 3 52
E 3 19
E 4 78
E 4 35
E 5 71
E 5 ED
E 5 5E
E 5 35
H 6 1
